// ==== dv/fpu_stimulus.txt ====
// opcode round operand_a operand_b result flags
// round 0 nearest-even 1 +inf 2 -inf 3 zero, flags 4 nan 2 inf 1 zero
// plain add and sub, carry, cancellation, negative result
0 0 3C00 4000 4200 0
1 0 4200 3C00 4000 0
0 0 3E00 3F00 4280 0
1 0 3C01 3C00 1400 0
1 0 3C00 4000 BC00 0
// 1 + 0.75 ulp under each mode
0 0 3C00 1200 3C01 0
0 1 3C00 1200 3C01 0
0 2 3C00 1200 3C00 0
0 3 3C00 1200 3C00 0
// same magnitude, negative sign
1 0 BC00 1200 BC01 0
1 1 BC00 1200 BC00 0
1 2 BC00 1200 BC01 0
1 3 BC00 1200 BC00 0
// exact ties, lsb even stays and lsb odd goes up
0 0 3C00 1000 3C00 0
0 0 3C01 1000 3C02 0
// nan in, inf plus one, inf minus inf, x minus x, overflow
0 0 7C01 3C00 7E00 4
0 0 7C00 3C00 7C00 2
1 0 7C00 7C00 7E00 4
1 0 4248 4248 0000 1
0 0 7BFF 7BFF 7C00 2
// subnormals, then two subnormals reaching the normal range
0 0 0001 0002 0003 0
0 0 0200 0200 0400 0

// ==== dv/fpu_tb.sv ====
module fpu_tb;

localparam int clk_half = 4;
// settle time after a falling edge before sampling
localparam int settle = 1;
localparam int num_rows = 22;
localparam int row_words = 6;
localparam int ready_timeout = 8;
localparam int done_timeout = 32;
// stimulus rows reused by the directed tests
localparam int row_one_plus_two = 0;
localparam int row_three_minus_one = 1;
localparam int row_nan_in = 15;
localparam int row_inf_plus_one = 16;

logic clk;
logic rst_n;
logic psel;
logic penable;
logic pwrite;
logic [7:0] paddr;
logic [31:0] pwdata;
logic [31:0] prdata;
logic pready;
logic pslverr;

// six words per row, see the stimulus file header
logic [15:0] stim_mem [0:num_rows * row_words - 1];
logic [31:0] rdata;
int rand_seed;
int discard;
int idx;

fpu_top dut
(
	.clk(clk),
	.rst_n(rst_n),
	.psel(psel),
	.penable(penable),
	.pwrite(pwrite),
	.paddr(paddr),
	.pwdata(pwdata),
	.prdata(prdata),
	.pready(pready),
	.pslverr(pslverr)
);

always #clk_half clk = ~clk;

task automatic abort_run(input string reason);
begin
	$display("%s", reason);
	$display("Finished with errors");
	$fatal(1);
end
endtask

task automatic check_value(input string name, input logic [31:0] actual,
	input logic [31:0] expected);
begin
	if (actual !== expected)
		abort_run($sformatf("Fail at time %0t: %s is %h, expected %h",
			$time, name, actual, expected));
end
endtask

// entered on a falling edge, returns on a falling edge with the bus idle
task automatic bus_transfer(input logic write, input logic [7:0] addr,
	input logic [31:0] wdata, output logic [31:0] data, output logic err);
	int waited;
begin
	psel = 1'b1;
	penable = 1'b0;
	pwrite = write;
	paddr = addr;
	pwdata = wdata;
	@(negedge clk);
	penable = 1'b1;
	#settle;
	waited = 0;
	while (pready !== 1'b1)
	begin
		if (waited >= ready_timeout)
			abort_run($sformatf("pready stayed low on access to %h", addr));
		@(negedge clk);
		#settle;
		waited++;
	end
	// access cycle, outputs stable until the next rising edge
	data = prdata;
	err = pslverr;
	@(negedge clk);
	psel = 1'b0;
	penable = 1'b0;
	pwrite = 1'b0;
end
endtask

task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
	input logic exp_err);
	logic [31:0] unused;
	logic err;
begin
	bus_transfer(1'b1, addr, data, unused, err);
	check_value($sformatf("pslverr on write to %h", addr), {31'b0, err}, {31'b0, exp_err});
end
endtask

task automatic apb_read(input logic [7:0] addr, input logic exp_err,
	output logic [31:0] data);
	logic err;
begin
	bus_transfer(1'b0, addr, 32'h0, data, err);
	check_value($sformatf("pslverr on read of %h", addr), {31'b0, err}, {31'b0, exp_err});
end
endtask

task automatic idle_cycles(input int n);
begin
	repeat (n) @(negedge clk);
end
endtask

// packed status word from the register map
function automatic logic [31:0] status_word(input logic busy_bit, input logic done_bit,
	input logic [2:0] flags);
	logic [31:0] word;
begin
	word = '0;
	word[fpu_types_pkg::status_busy_bit] = busy_bit;
	word[fpu_types_pkg::status_done_bit] = done_bit;
	word[fpu_types_pkg::status_nan_bit] = flags[2];
	word[fpu_types_pkg::status_inf_bit] = flags[1];
	word[fpu_types_pkg::status_zero_bit] = flags[0];
	return word;
end
endfunction

// operands, then ctrl with the start bit as the last transfer
task automatic start_op(input int row);
	int base;
	logic [31:0] ctrl;
begin
	base = row * row_words;
	ctrl = '0;
	ctrl[fpu_types_pkg::ctrl_opcode_bit] = stim_mem[base][0];
	ctrl[fpu_types_pkg::ctrl_round_lsb +: 2] = stim_mem[base + 1][1:0];
	ctrl[fpu_types_pkg::ctrl_start_bit] = 1'b1;
	apb_write(fpu_types_pkg::REG_OPERAND_A, {16'b0, stim_mem[base + 2]}, 1'b0);
	apb_write(fpu_types_pkg::REG_OPERAND_B, {16'b0, stim_mem[base + 3]}, 1'b0);
	apb_write(fpu_types_pkg::REG_CTRL, ctrl, 1'b0);
end
endtask

// done of the previous op can still show while busy, so wait for both
task automatic wait_done;
	logic [31:0] status;
	int polls;
begin
	polls = 0;
	apb_read(fpu_types_pkg::REG_STATUS, 1'b0, status);
	while (status[fpu_types_pkg::status_done_bit] !== 1'b1
		|| status[fpu_types_pkg::status_busy_bit] !== 1'b0)
	begin
		if (polls >= done_timeout)
			abort_run($sformatf("done not set after %0d status reads", done_timeout));
		apb_read(fpu_types_pkg::REG_STATUS, 1'b0, status);
		polls++;
	end
end
endtask

// clear flags, run one row, check result and flags
task automatic run_row(input int row);
	int base;
	logic [31:0] data;
begin
	base = row * row_words;
	apb_write(fpu_types_pkg::REG_STATUS, 32'h0, 1'b0);
	start_op(row);
	wait_done();
	apb_read(fpu_types_pkg::REG_RESULT, 1'b0, data);
	check_value($sformatf("result of row %0d", row), data, {16'b0, stim_mem[base + 4]});
	apb_read(fpu_types_pkg::REG_STATUS, 1'b0, data);
	check_value($sformatf("status of row %0d", row), data,
		status_word(1'b0, 1'b1, stim_mem[base + 5][2:0]));
end
endtask

initial
begin
	rand_seed = 2;
	discard = $urandom(rand_seed);
	clk = 1'b0;
	rst_n = 1'b0;
	psel = 1'b0;
	penable = 1'b0;
	pwrite = 1'b0;
	paddr = 8'h0;
	pwdata = 32'h0;

	// fill first so a short file shows up as bad opcodes
	for (idx = 0; idx < num_rows * row_words; idx++)
		stim_mem[idx] = 16'hA000 ^ 16'(idx);
	$readmemh("dv/fpu_stimulus.txt", stim_mem);
	for (idx = 0; idx < num_rows; idx++)
	begin
		if (stim_mem[idx * row_words] > 1 || stim_mem[idx * row_words + 1] > 3
			|| stim_mem[idx * row_words + 5] > 7)
			abort_run($sformatf("stimulus file is short or row %0d is malformed", idx));
	end

	repeat (16) @(negedge clk);
	rst_n = 1'b1;

	// reset values
	apb_read(fpu_types_pkg::REG_STATUS, 1'b0, rdata);
	check_value("status after reset", rdata, 32'h0);
	apb_read(fpu_types_pkg::REG_RESULT, 1'b0, rdata);
	check_value("result after reset", rdata, 32'h0);
	apb_read(fpu_types_pkg::REG_OPERAND_A, 1'b0, rdata);
	check_value("operand_a after reset", rdata, 32'h0);

	// every row with random idle gaps
	for (idx = 0; idx < num_rows; idx++)
	begin
		idle_cycles($urandom % 4);
		run_row(idx);
	end

	// sticky flags over two ops, then cleared by a status write
	apb_write(fpu_types_pkg::REG_STATUS, 32'h0, 1'b0);
	start_op(row_nan_in);
	wait_done();
	start_op(row_inf_plus_one);
	wait_done();
	apb_read(fpu_types_pkg::REG_STATUS, 1'b0, rdata);
	check_value("status after nan then inf", rdata, status_word(1'b0, 1'b1, 3'b110));
	apb_write(fpu_types_pkg::REG_STATUS, 32'h0, 1'b0);
	apb_read(fpu_types_pkg::REG_STATUS, 1'b0, rdata);
	check_value("status after clear", rdata, 32'h0);

	// back to back reads right after start, both before done
	start_op(row_one_plus_two);
	apb_read(fpu_types_pkg::REG_STATUS, 1'b0, rdata);
	check_value("status first read after start", rdata, status_word(1'b1, 1'b0, 3'b000));
	apb_read(fpu_types_pkg::REG_STATUS, 1'b0, rdata);
	check_value("status second read after start", rdata, status_word(1'b1, 1'b0, 3'b000));
	wait_done();
	apb_read(fpu_types_pkg::REG_RESULT, 1'b0, rdata);
	check_value("result of 1.0 + 2.0", rdata, 32'h4200);

	// one idle cycle, busy, then done on the next read
	start_op(row_three_minus_one);
	idle_cycles(1);
	apb_read(fpu_types_pkg::REG_STATUS, 1'b0, rdata);
	check_value("status one cycle after start", rdata, status_word(1'b1, 1'b0, 3'b000));
	apb_read(fpu_types_pkg::REG_STATUS, 1'b0, rdata);
	check_value("status at fixed latency", rdata, status_word(1'b0, 1'b1, 3'b000));
	apb_read(fpu_types_pkg::REG_RESULT, 1'b0, rdata);
	check_value("result of 3.0 - 1.0", rdata, 32'h4000);

	// bus errors
	apb_read(8'h14, 1'b1, rdata);
	apb_write(fpu_types_pkg::REG_RESULT, 32'h1234, 1'b1);
	start_op(row_one_plus_two);
	// second start as a subtract, must be rejected
	apb_write(fpu_types_pkg::REG_CTRL, 32'h11, 1'b1);
	wait_done();
	apb_read(fpu_types_pkg::REG_RESULT, 1'b0, rdata);
	check_value("result after rejected start", rdata, 32'h4200);
	apb_read(fpu_types_pkg::REG_CTRL, 1'b0, rdata);
	check_value("ctrl after rejected start", rdata, 32'h0);

	$display("Finished with no errors");
	$finish;
end

endmodule

// ==== flist.f ====
logic/fpu_types_pkg.sv
logic/float_add.sv
logic/fpu_apb_regs.sv
logic/fpu_issue.sv
logic/fpu_result_stage.sv
logic/fpu_top.sv
dv/fpu_tb.sv

// ==== logic/float_add.sv ====
module float_add
#(
	parameter int FLOAT_WIDTH = fpu_types_pkg::half_float_w,
	parameter int EXPONENT_WIDTH = fpu_types_pkg::half_exponent_w,
	parameter int FRACTION_WIDTH = fpu_types_pkg::half_fraction_w,
	parameter logic [FLOAT_WIDTH - 1 : 0] FLOAT_NAN = fpu_types_pkg::half_nan,
	parameter logic [FLOAT_WIDTH - 1 : 0] FLOAT_INF = fpu_types_pkg::half_inf,
	parameter logic [FLOAT_WIDTH - 1 : 0] FLOAT_INFN = fpu_types_pkg::half_infn,
	parameter logic [FLOAT_WIDTH - 1 : 0] FLOAT_ZERO = fpu_types_pkg::half_zero
)
(
	input logic [FLOAT_WIDTH - 1 : 0] float1,
	input logic [FLOAT_WIDTH - 1 : 0] float2,
	input fpu_types_pkg::fpu_rounding_mode_t rounding_mode,
	output logic [FLOAT_WIDTH - 1 : 0] sum
);

localparam int SIGN = FLOAT_WIDTH - 1;
localparam int EXP_LSB = FRACTION_WIDTH;
// hidden bit, fraction, then as many guard bits
localparam int MANT_W = 2 * FRACTION_WIDTH + 1;
localparam int MANT_MSB = MANT_W - 1;

logic a_larger;
logic sign_a;
logic sign_b;
logic [EXPONENT_WIDTH - 1 : 0] exponent_a;
logic [EXPONENT_WIDTH - 1 : 0] exponent_b;
logic [EXPONENT_WIDTH - 1 : 0] exp_eff_a;
logic [EXPONENT_WIDTH - 1 : 0] exp_eff_b;
logic [EXPONENT_WIDTH - 1 : 0] exponent_difference;
logic [EXPONENT_WIDTH - 1 : 0] exponent_out;
logic normal_a;
logic normal_b;
logic [MANT_W - 1 : 0] fraction_a;
logic [MANT_W - 1 : 0] fraction_b_full;
logic [MANT_W - 1 : 0] fraction_b;
logic [2 * MANT_W - 1 : 0] fraction_b_wide;
logic [MANT_W - 1 : 0] fraction_out;
logic align_sticky;
logic carry_out;
logic lost_bit;
logic round_bit;
logic sticky_bit;
logic round_up;
logic [SIGN - 1 : 0] rounded;
logic nan_in;
logic inf_1;
logic inf_2;

// magnitude compare, exponent and fraction together
assign a_larger = float1[SIGN - 1 : 0] >= float2[SIGN - 1 : 0];

// a is always the larger magnitude
assign sign_a = a_larger ? float1[SIGN] : float2[SIGN];
assign sign_b = a_larger ? float2[SIGN] : float1[SIGN];
assign exponent_a = a_larger ? float1[SIGN - 1 : EXP_LSB] : float2[SIGN - 1 : EXP_LSB];
assign exponent_b = a_larger ? float2[SIGN - 1 : EXP_LSB] : float1[SIGN - 1 : EXP_LSB];
assign normal_a = |exponent_a;
assign normal_b = |exponent_b;

assign fraction_a = {normal_a,
	a_larger ? float1[FRACTION_WIDTH - 1 : 0] : float2[FRACTION_WIDTH - 1 : 0],
	{FRACTION_WIDTH{1'b0}}};
assign fraction_b_full = {normal_b,
	a_larger ? float2[FRACTION_WIDTH - 1 : 0] : float1[FRACTION_WIDTH - 1 : 0],
	{FRACTION_WIDTH{1'b0}}};

// subnormals share the scale of exponent 1
assign exp_eff_a = normal_a ? exponent_a : EXPONENT_WIDTH'(1);
assign exp_eff_b = normal_b ? exponent_b : EXPONENT_WIDTH'(1);
assign exponent_difference = exp_eff_a - exp_eff_b;

// align b, bits shifted past the guard bits fold into the lsb
assign fraction_b_wide = {fraction_b_full, {MANT_W{1'b0}}} >> exponent_difference;
assign align_sticky = |fraction_b_wide[MANT_W - 1 : 0];
assign fraction_b = fraction_b_wide[2 * MANT_W - 1 : MANT_W] | MANT_W'(align_sticky);

// special operand classes
assign nan_in = (&float1[SIGN - 1 : EXP_LSB] & |float1[FRACTION_WIDTH - 1 : 0])
	| (&float2[SIGN - 1 : EXP_LSB] & |float2[FRACTION_WIDTH - 1 : 0]);
assign inf_1 = (float1 == FLOAT_INF) | (float1 == FLOAT_INFN);
assign inf_2 = (float2 == FLOAT_INF) | (float2 == FLOAT_INFN);

always_comb
begin
	carry_out = 1'b0;
	lost_bit = 1'b0;
	exponent_out = exponent_a;
	fraction_out = '0;

	if (sign_a == sign_b)
	begin
		// same signs, magnitudes add
		{carry_out, fraction_out} = fraction_a + fraction_b;
		if (carry_out)
		begin
			// one bit right, exponent up
			exponent_out = exponent_a + 1'b1;
			lost_bit = fraction_out[0];
			fraction_out = {carry_out, fraction_out[MANT_MSB : 1]};
		end
		else if (~normal_a & fraction_out[MANT_MSB])
		begin
			// two subnormals carried into the normal range
			exponent_out = EXPONENT_WIDTH'(1);
		end
	end
	else
	begin
		// opposite signs, a >= b so no borrow out
		fraction_out = fraction_a - fraction_b;
		if (normal_a)
		begin
			// renormalize, stop at the subnormal boundary
			for (int i = 0; i < MANT_W; i++)
			begin
				if (~fraction_out[MANT_MSB] & (exponent_out > EXPONENT_WIDTH'(1)))
				begin
					fraction_out = fraction_out << 1;
					exponent_out = exponent_out - 1'b1;
				end
			end
			// still no hidden bit, result is subnormal
			if (~fraction_out[MANT_MSB])
				exponent_out = '0;
		end
	end

	// round is first bit below the kept fraction
	round_bit = fraction_out[FRACTION_WIDTH - 1];
	sticky_bit = |fraction_out[FRACTION_WIDTH - 2 : 0] | lost_bit;

	case (rounding_mode)
		fpu_types_pkg::ROUND_NEAREST_EVEN:
			// ties go to the even lsb
			round_up = round_bit & (sticky_bit | fraction_out[FRACTION_WIDTH]);
		fpu_types_pkg::ROUND_INF:
			round_up = ~sign_a & (round_bit | sticky_bit);
		fpu_types_pkg::ROUND_INFN:
			round_up = sign_a & (round_bit | sticky_bit);
		fpu_types_pkg::ROUND_ZERO:
			round_up = 1'b0;
		default:
			round_up = 1'b0;
	endcase

	// increment may carry into exponent
	rounded = {exponent_out, fraction_out[MANT_MSB - 1 : FRACTION_WIDTH]} + SIGN'(round_up);

	if (nan_in)
		sum = FLOAT_NAN;
	else if (inf_1 | inf_2)
	begin
		if (inf_1 & inf_2)
			// inf + -inf is invalid
			sum = (sign_a == sign_b) ? (sign_a ? FLOAT_INFN : FLOAT_INF) : FLOAT_NAN;
		else
			// larger magnitude is the infinite one
			sum = sign_a ? FLOAT_INFN : FLOAT_INF;
	end
	else if (fraction_out == '0)
		// exact cancellation gives +0
		sum = FLOAT_ZERO;
	else if (&exponent_out)
		// exponent overflow saturates
		sum = sign_a ? FLOAT_INFN : FLOAT_INF;
	else
		sum = {sign_a, rounded};
end

endmodule

// ==== logic/fpu_apb_regs.sv ====
module fpu_apb_regs
#(
	parameter int FLOAT_WIDTH = fpu_types_pkg::half_float_w
)
(
	input logic clk,
	input logic rst_n,

	// apb slave
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [7:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,

	// towards issue stage
	output logic start,
	output logic [FLOAT_WIDTH - 1 : 0] operand_a,
	output logic [FLOAT_WIDTH - 1 : 0] operand_b,
	output fpu_types_pkg::fpu_opcode_t opcode,
	output fpu_types_pkg::fpu_rounding_mode_t rounding_mode,

	// result stage status
	output logic status_clear,
	input logic [FLOAT_WIDTH - 1 : 0] result,
	input logic busy,
	input logic done,
	input logic flag_nan,
	input logic flag_inf,
	input logic flag_zero
);

logic access;
logic wr_access;
logic addr_mapped;
logic start_req;
logic start_reject;
logic [31:0] read_mux;

// no wait states
assign pready = 1'b1;

// access phase of a transfer
assign access = psel & penable;
assign wr_access = access & pwrite;

// start bit written to ctrl
assign start_req = wr_access & (paddr == fpu_types_pkg::REG_CTRL)
	& pwdata[fpu_types_pkg::ctrl_start_bit];
// second start while an op is in flight
assign start_reject = start_req & busy;

assign pslverr = access & (~addr_mapped
	| (pwrite & (paddr == fpu_types_pkg::REG_RESULT))
	| start_reject);

// any status write clears done and flags
assign status_clear = wr_access & (paddr == fpu_types_pkg::REG_STATUS);

// address decode and read data, zero extended
always_comb
begin
	addr_mapped = 1'b1;
	read_mux = '0;
	case (paddr)
		fpu_types_pkg::REG_OPERAND_A:
			read_mux[FLOAT_WIDTH - 1 : 0] = operand_a;
		fpu_types_pkg::REG_OPERAND_B:
			read_mux[FLOAT_WIDTH - 1 : 0] = operand_b;
		fpu_types_pkg::REG_CTRL:
		begin
			// start reads back as zero
			read_mux[fpu_types_pkg::ctrl_opcode_bit] = opcode;
			read_mux[fpu_types_pkg::ctrl_round_lsb +: 2] = rounding_mode;
		end
		fpu_types_pkg::REG_STATUS:
		begin
			read_mux[fpu_types_pkg::status_busy_bit] = busy;
			read_mux[fpu_types_pkg::status_done_bit] = done;
			read_mux[fpu_types_pkg::status_nan_bit] = flag_nan;
			read_mux[fpu_types_pkg::status_inf_bit] = flag_inf;
			read_mux[fpu_types_pkg::status_zero_bit] = flag_zero;
		end
		fpu_types_pkg::REG_RESULT:
			read_mux[FLOAT_WIDTH - 1 : 0] = result;
		default:
			addr_mapped = 1'b0;
	endcase
end

always_ff @(posedge clk)
begin
	if (~rst_n)
	begin
		start <= 1'b0;
		operand_a <= '0;
		operand_b <= '0;
		opcode <= fpu_types_pkg::OP_ADD;
		rounding_mode <= fpu_types_pkg::ROUND_NEAREST_EVEN;
		prdata <= '0;
	end
	else
	begin
		// one cycle pulse, only when idle
		start <= start_req & ~busy;

		if (wr_access & (paddr == fpu_types_pkg::REG_OPERAND_A))
			operand_a <= pwdata[FLOAT_WIDTH - 1 : 0];
		if (wr_access & (paddr == fpu_types_pkg::REG_OPERAND_B))
			operand_b <= pwdata[FLOAT_WIDTH - 1 : 0];

		// rejected start leaves ctrl untouched
		if (wr_access & (paddr == fpu_types_pkg::REG_CTRL) & ~start_reject)
		begin
			opcode <= fpu_types_pkg::fpu_opcode_t'(pwdata[fpu_types_pkg::ctrl_opcode_bit]);
			rounding_mode <= fpu_types_pkg::fpu_rounding_mode_t'(
				pwdata[fpu_types_pkg::ctrl_round_lsb +: 2]);
		end

		// read data sampled in the setup cycle
		if (psel & ~penable & ~pwrite)
			prdata <= read_mux;
	end
end

endmodule

// ==== logic/fpu_issue.sv ====
module fpu_issue
#(
	parameter int FLOAT_WIDTH = fpu_types_pkg::half_float_w,
	parameter int EXPONENT_WIDTH = fpu_types_pkg::half_exponent_w,
	parameter int FRACTION_WIDTH = fpu_types_pkg::half_fraction_w,
	parameter logic [FLOAT_WIDTH - 1 : 0] FLOAT_NAN = fpu_types_pkg::half_nan,
	parameter logic [FLOAT_WIDTH - 1 : 0] FLOAT_INF = fpu_types_pkg::half_inf,
	parameter logic [FLOAT_WIDTH - 1 : 0] FLOAT_INFN = fpu_types_pkg::half_infn,
	parameter logic [FLOAT_WIDTH - 1 : 0] FLOAT_ZERO = fpu_types_pkg::half_zero
)
(
	input logic clk,
	input logic rst_n,
	input logic start,
	input logic [FLOAT_WIDTH - 1 : 0] operand_a,
	input logic [FLOAT_WIDTH - 1 : 0] operand_b,
	input fpu_types_pkg::fpu_opcode_t opcode,
	input fpu_types_pkg::fpu_rounding_mode_t rounding_mode,
	output logic sum_valid,
	output logic [FLOAT_WIDTH - 1 : 0] sum
);

logic sub_op;
logic add_valid;
logic [FLOAT_WIDTH - 1 : 0] float1_q;
logic [FLOAT_WIDTH - 1 : 0] float2_q;
fpu_types_pkg::fpu_rounding_mode_t rounding_mode_q;
logic [FLOAT_WIDTH - 1 : 0] add_sum;

// a - b computed as a + (-b)
assign sub_op = (opcode == fpu_types_pkg::OP_SUB);

// valid pipe, stage 1 then stage 2
always_ff @(posedge clk)
begin
	if (~rst_n)
	begin
		add_valid <= 1'b0;
		sum_valid <= 1'b0;
	end
	else
	begin
		add_valid <= start;
		sum_valid <= add_valid;
	end
end

always_ff @(posedge clk)
begin
	if (~rst_n)
	begin
		float1_q <= '0;
		float2_q <= '0;
		rounding_mode_q <= fpu_types_pkg::ROUND_NEAREST_EVEN;
		sum <= '0;
	end
	else
	begin
		// operand capture, b sign flipped for sub
		if (start)
		begin
			float1_q <= operand_a;
			float2_q <= {operand_b[FLOAT_WIDTH - 1] ^ sub_op,
				operand_b[FLOAT_WIDTH - 2 : 0]};
			rounding_mode_q <= rounding_mode;
		end
		// adder output
		if (add_valid)
			sum <= add_sum;
	end
end

float_add
#(
	.FLOAT_WIDTH(FLOAT_WIDTH),
	.EXPONENT_WIDTH(EXPONENT_WIDTH),
	.FRACTION_WIDTH(FRACTION_WIDTH),
	.FLOAT_NAN(FLOAT_NAN),
	.FLOAT_INF(FLOAT_INF),
	.FLOAT_INFN(FLOAT_INFN),
	.FLOAT_ZERO(FLOAT_ZERO)
)
u_float_add
(
	.float1(float1_q),
	.float2(float2_q),
	.rounding_mode(rounding_mode_q),
	.sum(add_sum)
);

endmodule

// ==== logic/fpu_result_stage.sv ====
module fpu_result_stage
#(
	parameter int FLOAT_WIDTH = fpu_types_pkg::half_float_w,
	parameter int EXPONENT_WIDTH = fpu_types_pkg::half_exponent_w,
	parameter int FRACTION_WIDTH = fpu_types_pkg::half_fraction_w
)
(
	input logic clk,
	input logic rst_n,
	input logic start,
	input logic sum_valid,
	input logic [FLOAT_WIDTH - 1 : 0] sum,
	input logic status_clear,
	output logic [FLOAT_WIDTH - 1 : 0] result,
	output logic busy,
	output logic done,
	output logic flag_nan,
	output logic flag_inf,
	output logic flag_zero
);

logic busy_q;
logic exp_ones;
logic frac_nonzero;
logic sum_nan;
logic sum_inf;
logic sum_zero;

// classify the value being captured
assign exp_ones = &sum[FRACTION_WIDTH +: EXPONENT_WIDTH];
assign frac_nonzero = |sum[FRACTION_WIDTH - 1 : 0];
assign sum_nan = exp_ones & frac_nonzero;
assign sum_inf = exp_ones & ~frac_nonzero;
// either signed zero
assign sum_zero = ~|sum[FLOAT_WIDTH - 2 : 0];

// start pulse counts as busy already
assign busy = busy_q | start;

always_ff @(posedge clk)
begin
	if (~rst_n)
	begin
		busy_q <= 1'b0;
		done <= 1'b0;
		result <= '0;
		flag_nan <= 1'b0;
		flag_inf <= 1'b0;
		flag_zero <= 1'b0;
	end
	else
	begin
		if (sum_valid)
			busy_q <= 1'b0;
		if (start)
			busy_q <= 1'b1;

		// new result wins over clear
		if (sum_valid)
			done <= 1'b1;
		else if (start | status_clear)
			done <= 1'b0;

		if (sum_valid)
			result <= sum;

		// sticky until a status write
		flag_nan <= (flag_nan & ~status_clear) | (sum_valid & sum_nan);
		flag_inf <= (flag_inf & ~status_clear) | (sum_valid & sum_inf);
		flag_zero <= (flag_zero & ~status_clear) | (sum_valid & sum_zero);
	end
end

endmodule

// ==== logic/fpu_top.sv ====
module fpu_top
#(
	parameter int FLOAT_WIDTH = fpu_types_pkg::half_float_w,
	parameter int EXPONENT_WIDTH = fpu_types_pkg::half_exponent_w,
	parameter int FRACTION_WIDTH = fpu_types_pkg::half_fraction_w
)
(
	input logic clk,
	input logic rst_n,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [7:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr
);

// special values built from the field widths
localparam logic [FLOAT_WIDTH - 1 : 0] FLOAT_INF =
	{{fpu_types_pkg::sign_w{1'b0}}, {EXPONENT_WIDTH{1'b1}}, {FRACTION_WIDTH{1'b0}}};
localparam logic [FLOAT_WIDTH - 1 : 0] FLOAT_INFN =
	{{fpu_types_pkg::sign_w{1'b1}}, {EXPONENT_WIDTH{1'b1}}, {FRACTION_WIDTH{1'b0}}};
// quiet nan, top fraction bit set
localparam logic [FLOAT_WIDTH - 1 : 0] FLOAT_NAN =
	{{fpu_types_pkg::sign_w{1'b0}}, {EXPONENT_WIDTH{1'b1}}, 1'b1, {(FRACTION_WIDTH - 1){1'b0}}};
localparam logic [FLOAT_WIDTH - 1 : 0] FLOAT_ZERO = '0;

logic start;
logic [FLOAT_WIDTH - 1 : 0] operand_a;
logic [FLOAT_WIDTH - 1 : 0] operand_b;
fpu_types_pkg::fpu_opcode_t opcode;
fpu_types_pkg::fpu_rounding_mode_t rounding_mode;
logic status_clear;
logic sum_valid;
logic [FLOAT_WIDTH - 1 : 0] sum;
logic [FLOAT_WIDTH - 1 : 0] result;
logic busy;
logic done;
logic flag_nan;
logic flag_inf;
logic flag_zero;

// software interface
fpu_apb_regs
#(
	.FLOAT_WIDTH(FLOAT_WIDTH)
)
u_regs
(
	.clk(clk),
	.rst_n(rst_n),
	.psel(psel),
	.penable(penable),
	.pwrite(pwrite),
	.paddr(paddr),
	.pwdata(pwdata),
	.prdata(prdata),
	.pready(pready),
	.pslverr(pslverr),
	.start(start),
	.operand_a(operand_a),
	.operand_b(operand_b),
	.opcode(opcode),
	.rounding_mode(rounding_mode),
	.status_clear(status_clear),
	.result(result),
	.busy(busy),
	.done(done),
	.flag_nan(flag_nan),
	.flag_inf(flag_inf),
	.flag_zero(flag_zero)
);

// two stage add pipe
fpu_issue
#(
	.FLOAT_WIDTH(FLOAT_WIDTH),
	.EXPONENT_WIDTH(EXPONENT_WIDTH),
	.FRACTION_WIDTH(FRACTION_WIDTH),
	.FLOAT_NAN(FLOAT_NAN),
	.FLOAT_INF(FLOAT_INF),
	.FLOAT_INFN(FLOAT_INFN),
	.FLOAT_ZERO(FLOAT_ZERO)
)
u_issue
(
	.clk(clk),
	.rst_n(rst_n),
	.start(start),
	.operand_a(operand_a),
	.operand_b(operand_b),
	.opcode(opcode),
	.rounding_mode(rounding_mode),
	.sum_valid(sum_valid),
	.sum(sum)
);

// result hold and status
fpu_result_stage
#(
	.FLOAT_WIDTH(FLOAT_WIDTH),
	.EXPONENT_WIDTH(EXPONENT_WIDTH),
	.FRACTION_WIDTH(FRACTION_WIDTH)
)
u_result
(
	.clk(clk),
	.rst_n(rst_n),
	.start(start),
	.sum_valid(sum_valid),
	.sum(sum),
	.status_clear(status_clear),
	.result(result),
	.busy(busy),
	.done(done),
	.flag_nan(flag_nan),
	.flag_inf(flag_inf),
	.flag_zero(flag_zero)
);

endmodule

// ==== logic/fpu_types_pkg.sv ====
package fpu_types_pkg;

	// half precision field widths
	localparam int half_float_w = 16;
	localparam int half_exponent_w = 5;
	localparam int half_fraction_w = 10;
	localparam int sign_w = 1;

	// special encodings
	localparam logic [half_float_w - 1 : 0] half_inf = 16'h7C00;
	localparam logic [half_float_w - 1 : 0] half_infn = 16'hFC00;
	localparam logic [half_float_w - 1 : 0] half_nan = 16'h7E00;
	localparam logic [half_float_w - 1 : 0] half_zero = 16'h0000;

	typedef enum logic [1:0] {
		ROUND_NEAREST_EVEN = 2'b00,
		ROUND_INF = 2'b01,
		ROUND_INFN = 2'b10,
		ROUND_ZERO = 2'b11
	} fpu_rounding_mode_t;

	// subtract is an add with operand b negated
	typedef enum logic {
		OP_ADD = 1'b0,
		OP_SUB = 1'b1
	} fpu_opcode_t;

	// apb byte offsets
	typedef enum logic [7:0] {
		REG_OPERAND_A = 8'h00,
		REG_OPERAND_B = 8'h04,
		REG_CTRL = 8'h08,
		REG_STATUS = 8'h0C,
		REG_RESULT = 8'h10
	} fpu_reg_addr_t;

	// ctrl register fields
	localparam int ctrl_opcode_bit = 0;
	localparam int ctrl_round_lsb = 1;
	localparam int ctrl_start_bit = 4;

	// status register fields
	localparam int status_busy_bit = 0;
	localparam int status_done_bit = 1;
	localparam int status_nan_bit = 2;
	localparam int status_inf_bit = 3;
	localparam int status_zero_bit = 4;

endpackage
